// ==== Bender.yml ====
package:
  name: core_v_mini_mcu

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mcu_pkg.sv
      - common/pwr_ctrl_if.sv
      - src/irq_mapper.sv
      - power_manager/pwr_domain_fsm.sv
      - power_manager/power_manager.sv
      - src/core_v_mini_mcu.sv

  - target: test
    include_dirs:
      - common
    files:
      - bench/tb_core_v_mini_mcu.sv

// ==== bench/tb_core_v_mini_mcu.sv ====
// ##########################################################################
// Testbench for the MCU top level, interrupt vector and power sequencing
// ##########################################################################

`timescale 1ns/10ps
`default_nettype none

`include "mcu_defs.svh"

module tb_core_v_mini_mcu;

  localparam int ND = 2 + `MCU_NUM_BANKS + `MCU_EXT_DOMAINS;
  // cycle budgets of the reset, irq, bank, retention, cpu and debug tests
  localparam int BUDGET = 10 + 210 + 60 + 40 + 120 + 60;
  localparam int TIMEOUT_CYCLES = 2 * BUDGET;

  // reference sequencer steps
  localparam int S_ON    = 0;
  localparam int S_CLK   = 1;
  localparam int S_ISO   = 2;
  localparam int S_RST   = 3;
  localparam int S_SWOFF = 4;
  localparam int S_OFF   = 5;
  localparam int S_SWON  = 6;
  localparam int S_UPRST = 7;
  localparam int S_UPISO = 8;
  localparam int S_RET   = 9;
  localparam int S_RETUP = 10;

  logic                          clk_i;
  logic                          reset_i;
  logic                          irq_software_i;
  logic                          irq_external_i;
  logic [`MCU_TIMER_W-1:0]       rv_timer_intr_i;
  logic                          dma_done_intr_i;
  logic                          spi_intr_i;
  logic                          spi_flash_intr_i;
  logic [`MCU_GPIO_AO_W-1:0]     gpio_ao_intr_i;
  logic [`MCU_INTR_W-1:0]        irq_o;
  logic                          cpu_sleep_i;
  logic                          cpu_powergate_en_i;
  logic                          debug_ndmreset_i;
  logic [1:0]                    peripheral_mode_i;
  logic [2*`MCU_NUM_BANKS-1:0]   bank_mode_i;
  logic [2*`MCU_EXT_DOMAINS-1:0] ext_mode_i;
  logic                          cpu_switch_no, cpu_iso_no, cpu_rst_no, cpu_switch_ack_ni;
  logic                          peripheral_switch_no, peripheral_iso_no, peripheral_rst_no;
  logic                          peripheral_retentive_no, peripheral_clkgate_en_no;
  logic                          peripheral_switch_ack_ni;
  logic [`MCU_NUM_BANKS-1:0]     bank_switch_no, bank_iso_no, bank_rst_no;
  logic [`MCU_NUM_BANKS-1:0]     bank_retentive_no, bank_clkgate_en_no, bank_switch_ack_ni;
  logic [`MCU_EXT_DOMAINS-1:0]   ext_switch_no, ext_iso_no, ext_rst_no;
  logic [`MCU_EXT_DOMAINS-1:0]   ext_retentive_no, ext_clkgate_en_no, ext_switch_ack_ni;

  // domains in the order cpu, peripheral, banks, external
  logic [ND-1:0] sw_all, iso_all, rst_all, ret_all, clk_all, ack_q;
  int            ack_wait [ND];
  int            m_step [ND];
  logic [ND-1:0] m_to_off;
  logic          m_pend;
  logic [31:0]   exp_irq;
  logic          exp_wake;
  logic [31:0]   rnd;
  logic          check_en;
  int            errors, tests_run, tests_passed, err0, cycle_cnt;

  assign sw_all  = {ext_switch_no, bank_switch_no, peripheral_switch_no, cpu_switch_no};
  assign iso_all = {ext_iso_no, bank_iso_no, peripheral_iso_no, cpu_iso_no};
  assign rst_all = {ext_rst_no, bank_rst_no, peripheral_rst_no, cpu_rst_no};
  // the cpu domain has no retention or clock gate output
  assign ret_all = {ext_retentive_no, bank_retentive_no, peripheral_retentive_no, 1'b1};
  assign clk_all = {ext_clkgate_en_no, bank_clkgate_en_no, peripheral_clkgate_en_no, 1'b1};
  assign {ext_switch_ack_ni, bank_switch_ack_ni, peripheral_switch_ack_ni,
          cpu_switch_ack_ni} = ack_q;

  core_v_mini_mcu core_v_mini_mcu_inst (.*);

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] irq_ref(input logic sw, input logic ext,
                                          input logic [3:0] tmr, input logic dma,
                                          input logic spi, input logic flash,
                                          input logic [7:0] gpio);
    logic [31:0] v;
    v = '0;
    v[3] = sw;
    v[7] = tmr[0];
    v[11] = ext;
    v[18:16] = tmr[3:1];
    v[19] = dma;
    v[20] = spi;
    v[21] = flash;
    v[29:22] = gpio;
    return v;
  endfunction

  // requested mode per domain with the cpu one following sleep and wake
  function automatic logic [1:0] mode_for(input int d);
    if (d == 0) begin
      return (cpu_sleep_i && cpu_powergate_en_i && !m_pend) ? mcu_pkg::PWR_OFF : mcu_pkg::PWR_ON;
    end else if (d == 1) begin
      return peripheral_mode_i;
    end else if (d < 2 + `MCU_NUM_BANKS) begin
      return bank_mode_i[2*(d-2) +: 2];
    end
    return ext_mode_i[2*(d-2-`MCU_NUM_BANKS) +: 2];
  endfunction

  function automatic int next_step(input int s, input logic to_off, input logic [1:0] mode,
                                   input logic ack_n);
    case (s)
      S_ON:    return (mode != mcu_pkg::PWR_ON) ? S_CLK : S_ON;
      S_CLK:   return S_ISO;
      S_ISO:   return to_off ? S_RST : S_RET;
      S_RST:   return S_SWOFF;
      S_SWOFF: return ack_n ? S_SWOFF : S_OFF;
      S_OFF:   return (mode != mcu_pkg::PWR_OFF) ? S_SWON : S_OFF;
      S_SWON:  return ack_n ? S_UPRST : S_SWON;
      S_UPRST: return S_UPISO;
      S_RET:   return (mode != mcu_pkg::PWR_RETAIN) ? S_RETUP : S_RET;
      S_RETUP: return S_UPISO;
      default: return S_ON;
    endcase
  endfunction

  // expected {switch, iso, reset, retention, clock gate}
  function automatic logic [4:0] ctrl_ref(input int s);
    case (s)
      S_CLK, S_UPISO:         return 5'b11110;
      S_ISO, S_UPRST, S_RETUP: return 5'b10110;
      S_RST, S_SWON:          return 5'b10010;
      S_SWOFF, S_OFF:         return 5'b00010;
      S_RET:                  return 5'b10100;
      default:                return 5'b11111;
    endcase
  endfunction

  function automatic logic [4:0] ctrl_of(input int d);
    return {sw_all[d], iso_all[d], rst_all[d], ret_all[d], clk_all[d]};
  endfunction

  // reference model stepping on the same edges as the DUT
  always @(posedge clk_i) begin
    if (reset_i) begin
      for (int d = 0; d < ND; d++) begin
        m_step[d] <= S_ON;
      end
      m_to_off <= '0;
      m_pend   <= 1'b0;
      exp_irq  <= '0;
      exp_wake <= 1'b0;
    end else begin
      for (int d = 0; d < ND; d++) begin
        m_step[d] <= next_step(m_step[d], m_to_off[d], mode_for(d), ack_q[d]);
        if (m_step[d] == S_ON) begin
          m_to_off[d] <= (mode_for(d) == mcu_pkg::PWR_OFF);
        end
      end
      exp_irq  <= irq_ref(irq_software_i, irq_external_i, rv_timer_intr_i, dma_done_intr_i,
                          spi_intr_i, spi_flash_intr_i, gpio_ao_intr_i);
      exp_wake <= |irq_ref(irq_software_i, irq_external_i, rv_timer_intr_i, dma_done_intr_i,
                           spi_intr_i, spi_flash_intr_i, gpio_ao_intr_i);
      if (exp_wake) begin
        m_pend <= 1'b1;
      end else if (m_step[0] == S_ON) begin
        m_pend <= 1'b0;
      end
    end
  end

  // switch cells answer after 1 to 4 cycles
  always @(posedge clk_i) begin
    #2;
    for (int d = 0; d < ND; d++) begin
      if (ack_q[d] !== sw_all[d]) begin
        if (ack_wait[d] == 0) begin
          ack_wait[d] = 1 + ($urandom % 4);
        end
        ack_wait[d] = ack_wait[d] - 1;
        if (ack_wait[d] == 0) begin
          ack_q[d] = sw_all[d];
        end
      end
    end
  end

  always @(negedge clk_i) begin : compare
    logic [4:0] want;
    logic [4:0] mask;
    if (check_en) begin
      assert (irq_o === exp_irq) else begin
        $display("CHECK FAILED at %0t: irq_o %h, expected %h", $time, irq_o, exp_irq);
        errors++;
      end
      for (int d = 0; d < ND; d++) begin
        want = ctrl_ref(m_step[d]);
        if (debug_ndmreset_i) begin
          want[2] = 1'b0;
        end
        mask = (d == 0) ? 5'b11100 : 5'b11111;
        assert ((ctrl_of(d) & mask) === (want & mask)) else begin
          $display("CHECK FAILED at %0t: domain %0d controls %b, expected %b",
                   $time, d, ctrl_of(d) & mask, want & mask);
          errors++;
        end
      end
    end
  end

  task automatic tick();
    @(posedge clk_i);
    #2;
  endtask

  task automatic wait_ctrl(input int d, input logic [4:0] want, input logic [4:0] mask,
                           input string what);
    int n;
    n = 0;
    while (((ctrl_of(d) & mask) != want) && n < 40) begin
      @(negedge clk_i);
      n++;
    end
    if ((ctrl_of(d) & mask) != want) begin
      $display("domain %0d did not reach %s within 40 cycles", d, what);
      errors++;
    end
  endtask

  task automatic wait_all_on(input string what);
    int n;
    n = 0;
    while ((sw_all & iso_all & rst_all & ret_all & clk_all) != '1 && n < 40) begin
      @(negedge clk_i);
      n++;
    end
    if ((sw_all & iso_all & rst_all & ret_all & clk_all) != '1) begin
      $display("domains did not all return on after %s", what);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - err_before);
    end
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("tests failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h4f74_551b));
    clk_i = 1'b0;
    reset_i = 1'b1;
    {irq_software_i, irq_external_i, rv_timer_intr_i, dma_done_intr_i} = '0;
    {spi_intr_i, spi_flash_intr_i, gpio_ao_intr_i} = '0;
    {cpu_sleep_i, cpu_powergate_en_i, debug_ndmreset_i} = '0;
    peripheral_mode_i = mcu_pkg::PWR_ON;
    bank_mode_i = '0;
    ext_mode_i = '0;
    ack_q = '1;
    for (int d = 0; d < ND; d++) begin
      ack_wait[d] = 0;
    end
    check_en = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_passed = 0;
    repeat (3) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    check_en = 1'b1;

    err0 = errors;
    @(negedge clk_i);
    assert (irq_o == '0 && (sw_all & iso_all & rst_all & ret_all & clk_all) == '1) else begin
      $display("CHECK FAILED at %0t: outputs not idle after reset", $time);
      errors++;
    end
    finish_test("reset", err0);

    err0 = errors;
    repeat (200) begin
      tick();
      rnd = $urandom;
      {irq_software_i, irq_external_i, rv_timer_intr_i, dma_done_intr_i, spi_intr_i,
       spi_flash_intr_i, gpio_ao_intr_i} = rnd[16:0];
    end
    tick();
    {irq_software_i, irq_external_i, rv_timer_intr_i, dma_done_intr_i} = '0;
    {spi_intr_i, spi_flash_intr_i, gpio_ao_intr_i} = '0;
    repeat (2) tick();
    finish_test("irq_random", err0);

    // bank 0 is domain 2
    err0 = errors;
    bank_mode_i[1:0] = mcu_pkg::PWR_OFF;
    wait_ctrl(2, 5'b00010, 5'b11111, "switch off");
    repeat (6) tick();
    bank_mode_i[1:0] = mcu_pkg::PWR_ON;
    wait_all_on("bank power up");
    finish_test("bank_off", err0);

    // external domain 1 is domain 7
    err0 = errors;
    tick();
    ext_mode_i[3:2] = mcu_pkg::PWR_RETAIN;
    wait_ctrl(7, 5'b10100, 5'b11111, "retention");
    repeat (4) tick();
    ext_mode_i[3:2] = mcu_pkg::PWR_ON;
    wait_all_on("retention exit");
    finish_test("ext_retain", err0);

    err0 = errors;
    tick();
    cpu_sleep_i = 1'b1;
    cpu_powergate_en_i = 1'b1;
    wait_ctrl(0, 5'b00000, 5'b11100, "cpu off");
    repeat (6) tick();
    irq_external_i = 1'b1;
    tick();
    irq_external_i = 1'b0;
    wait_ctrl(0, 5'b11100, 5'b11100, "cpu on after interrupt");
    tick();
    cpu_sleep_i = 1'b0;
    repeat (4) tick();
    cpu_sleep_i = 1'b1;
    wait_ctrl(0, 5'b00000, 5'b11100, "cpu off on the next sleep");
    tick();
    cpu_sleep_i = 1'b0;
    cpu_powergate_en_i = 1'b0;
    wait_all_on("cpu wake");
    finish_test("cpu_sleep_wake", err0);

    err0 = errors;
    tick();
    bank_mode_i[3:2] = mcu_pkg::PWR_RETAIN;
    ext_mode_i[1:0] = mcu_pkg::PWR_OFF;
    repeat (3) tick();
    debug_ndmreset_i = 1'b1;
    repeat (8) begin
      @(negedge clk_i);
      assert (rst_all == '0) else begin
        $display("CHECK FAILED at %0t: reset outputs %b under debug reset", $time, rst_all);
        errors++;
      end
      tick();
    end
    debug_ndmreset_i = 1'b0;
    bank_mode_i[3:2] = mcu_pkg::PWR_ON;
    ext_mode_i[1:0] = mcu_pkg::PWR_ON;
    wait_all_on("debug reset");
    finish_test("debug_reset", err0);

    $display("%0d of %0d tests passed, %0d check errors", tests_passed, tests_run, errors);
    if (errors == 0 && tests_passed == tests_run) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== common/mcu_defs.svh ====
// ##########################################################################
// MCU constants for the interrupt vector layout and the power domain counts
// ##########################################################################

`ifndef MCU_DEFS_SVH
`define MCU_DEFS_SVH

// memory banks with their own switch
`define MCU_NUM_BANKS 4

// power domains handed to the external subsystem
`define MCU_EXT_DOMAINS 2

// core interrupt vector and its fast field
`define MCU_INTR_W 32
`define MCU_FAST_INTR_W 15

// interrupt lines from the always-on GPIO and the timers
`define MCU_GPIO_AO_W 8
`define MCU_TIMER_W 4

`endif

// ==== common/mcu_pkg.sv ====
// ##########################################################################
// MCU types shared by the power manager and the domain sequencers
// ##########################################################################

`default_nettype none

package mcu_pkg;

  // mode requested for one power domain
  typedef enum logic [1:0] {
    PWR_ON     = 2'd0,
    PWR_RETAIN = 2'd1,
    PWR_OFF    = 2'd2
  } pwr_mode_e;

  // sequencer state, one step per control output change
  typedef enum logic [3:0] {
    ST_ON      = 4'd0,
    ST_CLK_OFF = 4'd1,
    ST_ISO_ON  = 4'd2,
    ST_RST_ON  = 4'd3,
    ST_SW_OFF  = 4'd4,
    ST_OFF     = 4'd5,
    ST_RET     = 4'd6,
    ST_SW_ON   = 4'd7,
    ST_RST_OFF = 4'd8,
    ST_ISO_OFF = 4'd9,
    ST_RET_OFF = 4'd10
  } pwr_state_e;

endpackage

`default_nettype wire

// ==== common/pwr_ctrl_if.sv ====
// ##########################################################################
// Control bundle of one power domain, all signals active low
// ##########################################################################

`timescale 1ns/10ps
`default_nettype none

interface pwr_ctrl_if;

  logic pwrgate_en_n;
  logic pwrgate_ack_n;
  logic isogate_en_n;
  logic rst_n;
  logic retentive_en_n;
  logic clkgate_en_n;

  // sequencer side drives the bundle and watches the switch
  modport seq (
    output pwrgate_en_n, isogate_en_n, rst_n, retentive_en_n, clkgate_en_n,
    input  pwrgate_ack_n
  );

  modport mgr (
    input  pwrgate_en_n, isogate_en_n, rst_n, retentive_en_n, clkgate_en_n,
    output pwrgate_ack_n
  );

endinterface

`default_nettype wire

// ==== power_manager/power_manager.sv ====
// ##########################################################################
// Power manager, picks the CPU mode and sequences every power domain
// ##########################################################################

`timescale 1ns/10ps
`default_nettype none

`include "mcu_defs.svh"

module power_manager (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        wake_i,
  input  logic                        cpu_sleep_i,
  input  logic                        cpu_powergate_en_i,
  input  logic                        debug_ndmreset_i,
  input  mcu_pkg::pwr_mode_e          peripheral_mode_i,
  input  mcu_pkg::pwr_mode_e          bank_mode_i [`MCU_NUM_BANKS],
  input  mcu_pkg::pwr_mode_e          ext_mode_i [`MCU_EXT_DOMAINS],
  output logic                        cpu_switch_no,
  output logic                        cpu_iso_no,
  output logic                        cpu_rst_no,
  input  logic                        cpu_switch_ack_ni,
  output logic                        peripheral_switch_no,
  output logic                        peripheral_iso_no,
  output logic                        peripheral_rst_no,
  output logic                        peripheral_retentive_no,
  output logic                        peripheral_clkgate_en_no,
  input  logic                        peripheral_switch_ack_ni,
  output logic [`MCU_NUM_BANKS-1:0]   bank_switch_no,
  output logic [`MCU_NUM_BANKS-1:0]   bank_iso_no,
  output logic [`MCU_NUM_BANKS-1:0]   bank_rst_no,
  output logic [`MCU_NUM_BANKS-1:0]   bank_retentive_no,
  output logic [`MCU_NUM_BANKS-1:0]   bank_clkgate_en_no,
  input  logic [`MCU_NUM_BANKS-1:0]   bank_switch_ack_ni,
  output logic [`MCU_EXT_DOMAINS-1:0] ext_switch_no,
  output logic [`MCU_EXT_DOMAINS-1:0] ext_iso_no,
  output logic [`MCU_EXT_DOMAINS-1:0] ext_rst_no,
  output logic [`MCU_EXT_DOMAINS-1:0] ext_retentive_no,
  output logic [`MCU_EXT_DOMAINS-1:0] ext_clkgate_en_no,
  input  logic [`MCU_EXT_DOMAINS-1:0] ext_switch_ack_ni
);

  // domain order: cpu, peripheral, banks, external
  localparam int NB      = `MCU_NUM_BANKS;
  localparam int NE      = `MCU_EXT_DOMAINS;
  localparam int NUM_DOM = 2 + NB + NE;

  mcu_pkg::pwr_mode_e   dom_mode [NUM_DOM];
  logic [NUM_DOM-1:0]   dom_on;
  logic [NUM_DOM-1:0]   sw_n, iso_n, rst_n, ret_n, clk_n, ack_n;
  logic                 wake_pend_q;

  pwr_ctrl_if dom_if [NUM_DOM] ();

  // a wake stays pending until the CPU domain is back on
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wake_pend_q <= 1'b0;
    end else if (wake_i) begin
      wake_pend_q <= 1'b1;
    end else if (dom_on[0]) begin
      wake_pend_q <= 1'b0;
    end
  end

  assign dom_mode[0] = (cpu_sleep_i && cpu_powergate_en_i && !wake_pend_q) ?
                       mcu_pkg::PWR_OFF : mcu_pkg::PWR_ON;
  assign dom_mode[1] = peripheral_mode_i;

  for (genvar b = 0; b < NB; b++) begin : g_bank_mode
    assign dom_mode[2+b] = bank_mode_i[b];
  end

  for (genvar e = 0; e < NE; e++) begin : g_ext_mode
    assign dom_mode[2+NB+e] = ext_mode_i[e];
  end

  assign ack_n = {ext_switch_ack_ni, bank_switch_ack_ni, peripheral_switch_ack_ni,
                  cpu_switch_ack_ni};

  for (genvar d = 0; d < NUM_DOM; d++) begin : g_dom
    pwr_domain_fsm u_fsm (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .mode_i  (dom_mode[d]),
      .is_on_o (dom_on[d]),
      .ctrl    (dom_if[d].seq)
    );

    assign sw_n[d]                 = dom_if[d].pwrgate_en_n;
    assign iso_n[d]                = dom_if[d].isogate_en_n;
    assign rst_n[d]                = dom_if[d].rst_n & ~debug_ndmreset_i;
    assign ret_n[d]                = dom_if[d].retentive_en_n;
    assign clk_n[d]                = dom_if[d].clkgate_en_n;
    assign dom_if[d].pwrgate_ack_n = ack_n[d];
  end

  assign cpu_switch_no = sw_n[0];
  assign cpu_iso_no    = iso_n[0];
  assign cpu_rst_no    = rst_n[0];

  assign peripheral_switch_no     = sw_n[1];
  assign peripheral_iso_no        = iso_n[1];
  assign peripheral_rst_no        = rst_n[1];
  assign peripheral_retentive_no  = ret_n[1];
  assign peripheral_clkgate_en_no = clk_n[1];

  assign bank_switch_no     = sw_n[2 +: NB];
  assign bank_iso_no        = iso_n[2 +: NB];
  assign bank_rst_no        = rst_n[2 +: NB];
  assign bank_retentive_no  = ret_n[2 +: NB];
  assign bank_clkgate_en_no = clk_n[2 +: NB];

  assign ext_switch_no     = sw_n[2+NB +: NE];
  assign ext_iso_no        = iso_n[2+NB +: NE];
  assign ext_rst_no        = rst_n[2+NB +: NE];
  assign ext_retentive_no  = ret_n[2+NB +: NE];
  assign ext_clkgate_en_no = clk_n[2+NB +: NE];

endmodule

`default_nettype wire

// ==== power_manager/pwr_domain_fsm.sv ====
// ##########################################################################
// Power domain sequencer, steps one domain between on, retention and off
// ##########################################################################

`timescale 1ns/10ps
`default_nettype none

module pwr_domain_fsm (
  input  logic              clk_i,
  input  logic              reset_i,
  input  mcu_pkg::pwr_mode_e mode_i,
  output logic              is_on_o,
  pwr_ctrl_if.seq           ctrl
);

  mcu_pkg::pwr_state_e state_q;
  mcu_pkg::pwr_state_e state_d;
  // target of the power down in flight, off or retention
  logic                to_off_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      mcu_pkg::ST_ON: begin
        if (mode_i != mcu_pkg::PWR_ON) begin
          state_d = mcu_pkg::ST_CLK_OFF;
        end
      end
      mcu_pkg::ST_CLK_OFF: state_d = mcu_pkg::ST_ISO_ON;
      mcu_pkg::ST_ISO_ON:  state_d = to_off_q ? mcu_pkg::ST_RST_ON : mcu_pkg::ST_RET;
      mcu_pkg::ST_RST_ON:  state_d = mcu_pkg::ST_SW_OFF;
      mcu_pkg::ST_SW_OFF: begin
        // switch cells may take any number of cycles
        if (!ctrl.pwrgate_ack_n) begin
          state_d = mcu_pkg::ST_OFF;
        end
      end
      mcu_pkg::ST_OFF: begin
        if (mode_i != mcu_pkg::PWR_OFF) begin
          state_d = mcu_pkg::ST_SW_ON;
        end
      end
      mcu_pkg::ST_RET: begin
        if (mode_i != mcu_pkg::PWR_RETAIN) begin
          state_d = mcu_pkg::ST_RET_OFF;
        end
      end
      mcu_pkg::ST_SW_ON: begin
        if (ctrl.pwrgate_ack_n) begin
          state_d = mcu_pkg::ST_RST_OFF;
        end
      end
      mcu_pkg::ST_RST_OFF: state_d = mcu_pkg::ST_ISO_OFF;
      mcu_pkg::ST_RET_OFF: state_d = mcu_pkg::ST_ISO_OFF;
      mcu_pkg::ST_ISO_OFF: state_d = mcu_pkg::ST_ON;
      default:             state_d = mcu_pkg::ST_ON;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= mcu_pkg::ST_ON;
      to_off_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == mcu_pkg::ST_ON) begin
        to_off_q <= (mode_i == mcu_pkg::PWR_OFF);
      end
    end
  end

  // control outputs follow the state directly
  always_comb begin
    ctrl.clkgate_en_n   = 1'b1;
    ctrl.isogate_en_n   = 1'b1;
    ctrl.rst_n          = 1'b1;
    ctrl.pwrgate_en_n   = 1'b1;
    ctrl.retentive_en_n = 1'b1;
    unique case (state_q)
      mcu_pkg::ST_CLK_OFF, mcu_pkg::ST_ISO_OFF: begin
        ctrl.clkgate_en_n = 1'b0;
      end
      mcu_pkg::ST_ISO_ON, mcu_pkg::ST_RST_OFF: begin
        ctrl.clkgate_en_n = 1'b0;
        ctrl.isogate_en_n = 1'b0;
      end
      mcu_pkg::ST_RST_ON, mcu_pkg::ST_SW_ON: begin
        ctrl.clkgate_en_n = 1'b0;
        ctrl.isogate_en_n = 1'b0;
        ctrl.rst_n        = 1'b0;
      end
      mcu_pkg::ST_SW_OFF, mcu_pkg::ST_OFF: begin
        ctrl.clkgate_en_n = 1'b0;
        ctrl.isogate_en_n = 1'b0;
        ctrl.rst_n        = 1'b0;
        ctrl.pwrgate_en_n = 1'b0;
      end
      mcu_pkg::ST_RET: begin
        ctrl.clkgate_en_n   = 1'b0;
        ctrl.isogate_en_n   = 1'b0;
        ctrl.retentive_en_n = 1'b0;
      end
      mcu_pkg::ST_RET_OFF: begin
        ctrl.clkgate_en_n = 1'b0;
        ctrl.isogate_en_n = 1'b0;
      end
      default: ;
    endcase
  end

  assign is_on_o = (state_q == mcu_pkg::ST_ON);

  // isolation was already in place the cycle before the switch opened
  a_iso_before_sw: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !ctrl.pwrgate_en_n |-> !ctrl.isogate_en_n && $past(!ctrl.isogate_en_n)
  ) else $error("pwr_domain_fsm: switch off without isolation");

  // reset is held through the switch off and the first cycle of power up
  a_rst_with_sw: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !ctrl.pwrgate_en_n |-> !ctrl.rst_n ##1 !ctrl.rst_n
  ) else $error("pwr_domain_fsm: reset released while switch off");

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+common
common/mcu_pkg.sv
common/pwr_ctrl_if.sv
src/irq_mapper.sv
power_manager/pwr_domain_fsm.sv
power_manager/power_manager.sv
src/core_v_mini_mcu.sv
bench/tb_core_v_mini_mcu.sv

// ==== src/core_v_mini_mcu.sv ====
// ##########################################################################
// MCU top level, interrupt mapping and power domain control
// ##########################################################################

`timescale 1ns/10ps
`default_nettype none

`include "mcu_defs.svh"

module core_v_mini_mcu (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          irq_software_i,
  input  logic                          irq_external_i,
  input  logic [`MCU_TIMER_W-1:0]       rv_timer_intr_i,
  input  logic                          dma_done_intr_i,
  input  logic                          spi_intr_i,
  input  logic                          spi_flash_intr_i,
  input  logic [`MCU_GPIO_AO_W-1:0]     gpio_ao_intr_i,
  output logic [`MCU_INTR_W-1:0]        irq_o,
  input  logic                          cpu_sleep_i,
  input  logic                          cpu_powergate_en_i,
  input  logic                          debug_ndmreset_i,
  input  logic [1:0]                    peripheral_mode_i,
  input  logic [2*`MCU_NUM_BANKS-1:0]   bank_mode_i,
  input  logic [2*`MCU_EXT_DOMAINS-1:0] ext_mode_i,
  output logic                          cpu_switch_no,
  output logic                          cpu_iso_no,
  output logic                          cpu_rst_no,
  input  logic                          cpu_switch_ack_ni,
  output logic                          peripheral_switch_no,
  output logic                          peripheral_iso_no,
  output logic                          peripheral_rst_no,
  output logic                          peripheral_retentive_no,
  output logic                          peripheral_clkgate_en_no,
  input  logic                          peripheral_switch_ack_ni,
  output logic [`MCU_NUM_BANKS-1:0]     bank_switch_no,
  output logic [`MCU_NUM_BANKS-1:0]     bank_iso_no,
  output logic [`MCU_NUM_BANKS-1:0]     bank_rst_no,
  output logic [`MCU_NUM_BANKS-1:0]     bank_retentive_no,
  output logic [`MCU_NUM_BANKS-1:0]     bank_clkgate_en_no,
  input  logic [`MCU_NUM_BANKS-1:0]     bank_switch_ack_ni,
  output logic [`MCU_EXT_DOMAINS-1:0]   ext_switch_no,
  output logic [`MCU_EXT_DOMAINS-1:0]   ext_iso_no,
  output logic [`MCU_EXT_DOMAINS-1:0]   ext_rst_no,
  output logic [`MCU_EXT_DOMAINS-1:0]   ext_retentive_no,
  output logic [`MCU_EXT_DOMAINS-1:0]   ext_clkgate_en_no,
  input  logic [`MCU_EXT_DOMAINS-1:0]   ext_switch_ack_ni
);

  logic               wake;
  mcu_pkg::pwr_mode_e bank_mode [`MCU_NUM_BANKS];
  mcu_pkg::pwr_mode_e ext_mode [`MCU_EXT_DOMAINS];

  // mode fields arrive packed two bits per domain
  for (genvar b = 0; b < `MCU_NUM_BANKS; b++) begin : g_bank_mode
    assign bank_mode[b] = mcu_pkg::pwr_mode_e'(bank_mode_i[2*b +: 2]);
  end

  for (genvar e = 0; e < `MCU_EXT_DOMAINS; e++) begin : g_ext_mode
    assign ext_mode[e] = mcu_pkg::pwr_mode_e'(ext_mode_i[2*e +: 2]);
  end

  irq_mapper u_irq_mapper (
    .clk_i, .reset_i, .irq_software_i, .irq_external_i, .rv_timer_intr_i,
    .dma_done_intr_i, .spi_intr_i, .spi_flash_intr_i, .gpio_ao_intr_i,
    .irq_o,
    .wake_o (wake)
  );

  power_manager u_power_manager (
    .clk_i, .reset_i,
    .wake_i            (wake),
    .cpu_sleep_i, .cpu_powergate_en_i, .debug_ndmreset_i,
    .peripheral_mode_i (mcu_pkg::pwr_mode_e'(peripheral_mode_i)),
    .bank_mode_i       (bank_mode),
    .ext_mode_i        (ext_mode),
    .cpu_switch_no, .cpu_iso_no, .cpu_rst_no, .cpu_switch_ack_ni,
    .peripheral_switch_no, .peripheral_iso_no, .peripheral_rst_no,
    .peripheral_retentive_no, .peripheral_clkgate_en_no, .peripheral_switch_ack_ni,
    .bank_switch_no, .bank_iso_no, .bank_rst_no, .bank_retentive_no,
    .bank_clkgate_en_no, .bank_switch_ack_ni,
    .ext_switch_no, .ext_iso_no, .ext_rst_no, .ext_retentive_no,
    .ext_clkgate_en_no, .ext_switch_ack_ni
  );

endmodule

`default_nettype wire

// ==== src/irq_mapper.sv ====
// ##########################################################################
// Interrupt mapper, packs the sources into the registered core irq vector
// ##########################################################################

`timescale 1ns/10ps
`default_nettype none

`include "mcu_defs.svh"

module irq_mapper (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      irq_software_i,
  input  logic                      irq_external_i,
  input  logic [`MCU_TIMER_W-1:0]   rv_timer_intr_i,
  input  logic                      dma_done_intr_i,
  input  logic                      spi_intr_i,
  input  logic                      spi_flash_intr_i,
  input  logic [`MCU_GPIO_AO_W-1:0] gpio_ao_intr_i,
  output logic [`MCU_INTR_W-1:0]    irq_o,
  output logic                      wake_o
);

  // bits that carry no source, everything but 3, 7, 11 and 16 to 30
  localparam logic [`MCU_INTR_W-1:0] RSVD_MASK = ~(32'h7fff_0000 | 32'h0000_0888);

  logic [`MCU_FAST_INTR_W-1:0] fast_intr;
  logic [`MCU_INTR_W-1:0]      intr_d;

  // timer 0 sits in the standard timer slot, the others go fast
  assign fast_intr = {
    1'b0,
    gpio_ao_intr_i,
    spi_flash_intr_i,
    spi_intr_i,
    dma_done_intr_i,
    rv_timer_intr_i[3],
    rv_timer_intr_i[2],
    rv_timer_intr_i[1]
  };

  assign intr_d = {
    1'b0, fast_intr, 4'b0, irq_external_i, 3'b0, rv_timer_intr_i[0], 3'b0, irq_software_i, 3'b0
  };

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      irq_o  <= '0;
      wake_o <= 1'b0;
    end else begin
      irq_o  <= intr_d;
      wake_o <= |intr_d;
    end
  end

  a_rsvd_zero: assert property (
    @(posedge clk_i) disable iff (reset_i) (irq_o & RSVD_MASK) == '0
  ) else $error("irq_mapper: reserved interrupt bit set, irq_o=%h", irq_o);

endmodule

`default_nettype wire
